// ==== compile.f ====
source/lc3b_types.sv
source/control_rom.sv
source/lc3b_control.sv
source/lc3b_regfile.sv
source/lc3b_alu.sv
source/lc3b_datapath.sv
source/lc3b_core.sv
testbench/tb_clock.sv
testbench/lc3b_tb.sv

// ==== Makefile ====
.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove the build output"
	@echo "make help   show this list"

test:
	verilator --binary --timing -j 0 --top-module lc3b_tb -f compile.f -o lc3b_sim
	./obj_dir/lc3b_sim | tee /dev/stderr | grep -q "^Test completed successfully$$"

clean:
	rm -rf obj_dir

// ==== testbench/lc3b_tb.sv ====
`timescale 1ns/1ps

module lc3b_tb;

   localparam int mem_words = 1024;
   localparam int cycles_per_instr = 200;
   localparam int data_base = 768; // word index of byte address 0x600

   typedef struct packed {
      logic [15:0] addr;
      logic [15:0] data;
      logic [1:0]  byte_en;
   } store_rec;

   logic                    clk;
   logic                    reset;
   lc3b_types::lc3b_mem_req mem_req;
   lc3b_types::lc3b_mem_rsp mem_rsp;
   logic                    ack;
   logic [15:0]             rdata;

   logic [15:0] mem [mem_words];
   logic [15:0] image [mem_words];
   logic [15:0] ref_img [mem_words];
   logic [31:0] lcg_state;
   store_rec    exp_q [$];
   store_rec    got;
   int          pos;
   int          wait_left;
   int          release_left;
   int          errors;
   int          got_idx;
   int          n_instr;
   logic        write_seen;
   logic        req_prev;
   logic        ref_ready;
   logic [15:0] halt_addr;

   tb_clock clock_gen (
      .clk   (clk),
      .reset (reset)
   );

   lc3b_core #(
      .reset_pc (16'h0000)
   ) DUT (
      .clk     (clk),
      .reset   (reset),
      .mem_req (mem_req),
      .mem_rsp (mem_rsp)
   );

   assign mem_rsp.ack = ack;
   assign mem_rsp.rdata = rdata;

   function automatic logic [31:0] lcg_step(logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   function automatic logic [15:0] draw_word();
      lcg_state = lcg_step(lcg_state);
      return lcg_state[31:16]; // upper bits are the better ones
   endfunction

   function automatic logic [15:0] alu_reg(logic [3:0] op, int dr, int sr1, int sr2);
      return {op, 3'(dr), 3'(sr1), 3'b000, 3'(sr2)};
   endfunction

   function automatic logic [15:0] alu_imm(logic [3:0] op, int dr, int sr1, int imm);
      return {op, 3'(dr), 3'(sr1), 1'b1, 5'(imm)};
   endfunction

   function automatic logic [15:0] not_word(int dr, int sr);
      return {4'b1001, 3'(dr), 3'(sr), 6'b111111};
   endfunction

   function automatic logic [15:0] shf_word(int dr, int sr, int mode, int amt);
      return {4'b1101, 3'(dr), 3'(sr), 2'(mode), 4'(amt)}; // mode is {a, d}
   endfunction

   function automatic logic [15:0] mem_word(logic [3:0] op, int r, int base, int off);
      return {op, 3'(r), 3'(base), 6'(off)};
   endfunction

   function automatic logic [15:0] br_word(int nzp, int off);
      return {4'b0000, 3'(nzp), 9'(off)};
   endfunction

   function automatic logic [15:0] lea_word(int dr, int off);
      return {4'b1110, 3'(dr), 9'(off)};
   endfunction

   function automatic logic [15:0] jsr_word(int off);
      return {4'b0100, 1'b1, 11'(off)};
   endfunction

   function automatic logic [15:0] jsrr_word(int base);
      return {4'b0100, 3'b000, 3'(base), 6'b000000};
   endfunction

   function automatic logic [15:0] jmp_word(int base);
      return {4'b1100, 3'b000, 3'(base), 6'b000000};
   endfunction

   task automatic put(logic [15:0] w);
      image[pos] = w;
      pos++;
   endtask

   // store a register through r5 and step the pointer
   task automatic save(int r);
      put(mem_word(lc3b_types::op_str, r, 5, 0));
      put(alu_imm(lc3b_types::op_add, 5, 5, 2));
   endtask

   task automatic build_program();
      pos = 0;
      put(br_word(7, 3)); // over the subroutine
      put(mem_word(lc3b_types::op_str, 7, 5, 0));
      put(alu_imm(lc3b_types::op_add, 5, 5, 2));
      put(jmp_word(7)); // ret
      put(alu_imm(lc3b_types::op_add, 6, 0, 12));
      put(shf_word(6, 6, 0, 7)); // r6 = 0x600 data
      put(alu_imm(lc3b_types::op_add, 5, 0, 14));
      put(shf_word(5, 5, 0, 7)); // r5 = 0x700 results
      put(mem_word(lc3b_types::op_ldr, 1, 6, 0));
      put(mem_word(lc3b_types::op_ldr, 2, 6, 1));
      put(alu_reg(lc3b_types::op_add, 3, 1, 2));
      save(3);
      put(alu_imm(lc3b_types::op_add, 3, 1, -7));
      save(3);
      put(alu_reg(lc3b_types::op_and, 3, 1, 2));
      save(3);
      put(alu_imm(lc3b_types::op_and, 3, 2, 13));
      save(3);
      put(not_word(3, 1));
      save(3);
      put(shf_word(3, 1, 0, 5));
      save(3);
      put(shf_word(3, 2, 1, 3));
      save(3);
      put(shf_word(3, 2, 3, 7)); // r2 is negative
      save(3);
      put(shf_word(3, 1, 3, 11));
      save(3);
      put(mem_word(lc3b_types::op_ldb, 3, 6, 0));
      save(3);
      put(mem_word(lc3b_types::op_ldb, 3, 6, 1));
      save(3);
      put(mem_word(lc3b_types::op_ldb, 3, 6, 5));
      save(3);
      put(mem_word(lc3b_types::op_stb, 1, 5, 0));
      put(mem_word(lc3b_types::op_stb, 2, 5, 1));
      put(mem_word(lc3b_types::op_ldr, 3, 5, 0)); // merged bytes
      save(3);
      put(mem_word(lc3b_types::op_str, 2, 6, 3));
      put(mem_word(lc3b_types::op_ldr, 4, 6, 3));
      save(4);
      put(mem_word(lc3b_types::op_ldb, 4, 6, 7));
      save(4);
      for (int v = -1; v <= 1; v++) begin
         for (int nzp = 0; nzp < 8; nzp++) begin
            put(alu_imm(lc3b_types::op_add, 3, 0, v * 5));
            put(br_word(nzp, 2));
            put(alu_imm(lc3b_types::op_add, 4, 0, 1)); // not taken marker
            put(br_word(7, 1));
            put(alu_imm(lc3b_types::op_add, 4, 0, 2)); // taken marker
            save(4);
         end
      end
      put(jsr_word(-pos)); // subroutine sits at byte 2
      put(alu_imm(lc3b_types::op_add, 4, 0, 9));
      save(4);
      put(lea_word(2, -pos));
      put(jsrr_word(2));
      save(7);
      halt_addr = 16'(pos * 2);
      put(br_word(7, -1));
   endtask

   // ISA level model that returns the number of instructions run
   function automatic int lc3b_ref();
      logic [15:0] r [8];
      logic [15:0] pc;
      logic [15:0] ir;
      logic [15:0] ea;
      logic [15:0] b;
      logic [15:0] res;
      logic [15:0] w;
      logic [2:0]  cc;
      logic [7:0]  bt;
      logic        wr;
      store_rec    s;
      int          count;
      for (int i = 0; i < 8; i++)
         r[i] = 16'h0000;
      pc = 16'h0000;
      cc = 3'b010;
      count = 0;
      while (count < 100000) begin
         ir = ref_img[pc[10:1]];
         count++;
         if (ir[15:12] == 4'b0000 && (ir[11:9] & cc) != 3'b000 && ir[8:0] == 9'h1ff)
            return count; // branch to self
         pc = pc + 16'd2;
         wr = 1'b0;
         res = 16'h0000;
         b = ir[5] ? {{11{ir[4]}}, ir[4:0]} : r[ir[2:0]];
         case (ir[15:12])
            4'b0001: begin
               res = r[ir[8:6]] + b;
               wr = 1'b1;
            end
            4'b0101: begin
               res = r[ir[8:6]] & b;
               wr = 1'b1;
            end
            4'b1001: begin
               res = ~r[ir[8:6]];
               wr = 1'b1;
            end
            4'b1101: begin
               if (!ir[4])
                  res = r[ir[8:6]] << ir[3:0];
               else if (!ir[5])
                  res = r[ir[8:6]] >> ir[3:0];
               else
                  res = $signed(r[ir[8:6]]) >>> ir[3:0];
               wr = 1'b1;
            end
            4'b1110: r[ir[11:9]] = pc + {{6{ir[8]}}, ir[8:0], 1'b0};
            4'b0110: begin
               ea = r[ir[8:6]] + {{9{ir[5]}}, ir[5:0], 1'b0};
               res = ref_img[ea[10:1]];
               wr = 1'b1;
            end
            4'b0010: begin
               ea = r[ir[8:6]] + {{10{ir[5]}}, ir[5:0]};
               w = ref_img[ea[10:1]];
               res = {8'h00, (ea[0] ? w[15:8] : w[7:0])};
               wr = 1'b1;
            end
            4'b0111: begin
               ea = r[ir[8:6]] + {{9{ir[5]}}, ir[5:0], 1'b0};
               ref_img[ea[10:1]] = r[ir[11:9]];
               s.addr = ea;
               s.data = r[ir[11:9]];
               s.byte_en = 2'b11;
               exp_q.push_back(s);
            end
            4'b0011: begin
               ea = r[ir[8:6]] + {{10{ir[5]}}, ir[5:0]};
               bt = r[ir[11:9]][7:0];
               if (ea[0])
                  ref_img[ea[10:1]][15:8] = bt;
               else
                  ref_img[ea[10:1]][7:0] = bt;
               s.addr = ea;
               s.data = {bt, bt};
               s.byte_en = ea[0] ? 2'b10 : 2'b01;
               exp_q.push_back(s);
            end
            4'b0000: begin
               if ((ir[11:9] & cc) != 3'b000)
                  pc = pc + {{6{ir[8]}}, ir[8:0], 1'b0};
            end
            4'b1100: pc = r[ir[8:6]];
            4'b0100: begin
               w = pc;
               if (ir[11])
                  pc = pc + {{4{ir[10]}}, ir[10:0], 1'b0};
               else
                  pc = r[ir[8:6]];
               r[7] = w;
            end
            default: ;
         endcase
         if (wr) begin
            r[ir[11:9]] = res;
            cc = {res[15], res == 16'h0000, !res[15] && res != 16'h0000};
         end
      end
      return count;
   endfunction

   // memory model with ack after 1 to 4 cycles and a random hold once req falls
   always @(posedge clk) begin
      if (!reset && !ack && mem_req.req) begin
         if (wait_left == 0) begin
            ack <= 1'b1;
            rdata <= mem[mem_req.addr[10:1]];
            if (mem_req.we && mem_req.byte_en[0])
               mem[mem_req.addr[10:1]][7:0] <= mem_req.wdata[7:0];
            if (mem_req.we && mem_req.byte_en[1])
               mem[mem_req.addr[10:1]][15:8] <= mem_req.wdata[15:8];
            wait_left = int'(draw_word() % 16'd4);
         end else begin
            wait_left--;
         end
      end else if (ack && !mem_req.req) begin
         if (release_left == 0) begin
            ack <= 1'b0;
            release_left = int'(draw_word() % 16'd4);
         end else begin
            release_left--;
         end
      end
   end

   always @(posedge clk) begin
      if (!reset) begin
         assert (!(mem_req.req && !req_prev && mem_rsp.ack)) else begin
            errors++;
            $display("at %0t a new request was raised while ack was still high", $time);
         end
         if (!mem_req.req) begin
            write_seen = 1'b0;
         end else if (mem_req.we && mem_rsp.ack && !write_seen) begin
            write_seen = 1'b1;
            got.addr = mem_req.addr;
            got.data = mem_req.wdata;
            got.byte_en = mem_req.byte_en;
            assert (got_idx < exp_q.size()) else begin
               errors++;
               $display("at %0t the core wrote more stores than the program has", $time);
            end
            if (got_idx < exp_q.size()) begin
               assert (got == exp_q[got_idx]) else begin
                  errors++;
                  $display("[ERROR] %0t store %0d expected %h/%h/%b got %h/%h/%b", $time,
                           got_idx, exp_q[got_idx].addr, exp_q[got_idx].data,
                           exp_q[got_idx].byte_en, got.addr, got.data, got.byte_en);
               end
            end
            got_idx++;
         end
      end
      req_prev = mem_req.req;
   end

   initial begin
      errors = 0;
      got_idx = 0;
      write_seen = 1'b0;
      req_prev = 1'b0;
      ref_ready = 1'b0;
      lcg_state = 32'hb215_b374;
      ack <= 1'b0;
      rdata <= 16'h0000;
      for (int i = 0; i < mem_words; i++)
         image[i] = (16'(i) * 16'h9e37) ^ 16'h5a5a; // address hash fill
      for (int i = 0; i < 16; i++)
         image[data_base + i] = draw_word();
      image[data_base + 1] = image[data_base + 1] | 16'h8000;
      build_program();
      ref_img = image;
      n_instr = lc3b_ref();
      for (int i = 0; i < mem_words; i++)
         mem[i] <= image[i];
      wait_left = int'(draw_word() % 16'd4);
      release_left = int'(draw_word() % 16'd4);
      ref_ready = 1'b1;
      wait (!reset);
      while (got_idx < exp_q.size())
         @(posedge clk);
      do
         @(posedge clk);
      while (!(mem_req.req && !mem_req.we && mem_req.addr == halt_addr));
      repeat (4) @(posedge clk);
      $display("stores checked %0d of %0d, errors %0d", got_idx, exp_q.size(), errors);
      if (errors == 0)
         $display("Test completed successfully");
      else
         $display("Test failed");
      $finish;
   end

   initial begin
      wait (ref_ready);
      repeat (16 + n_instr * cycles_per_instr) @(posedge clk);
      $display("timeout, the core did not finish the program in time");
      $display("stores checked %0d of %0d, errors %0d", got_idx, exp_q.size(), errors);
      $display("Test failed");
      $finish;
   end

endmodule : lc3b_tb

// ==== testbench/tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock (
   output logic clk,
   output logic reset
);

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk; // 10 ns period
   end

   initial begin
      reset = 1'b1;
      repeat (16) @(posedge clk);
      reset <= 1'b0;
   end

endmodule : tb_clock

// ==== source/lc3b_core.sv ====
`timescale 1ns/1ps

module lc3b_core #(
   parameter lc3b_types::lc3b_word reset_pc = 16'h0000
) (
   input  logic                    clk,
   input  logic                    reset,
   output lc3b_types::lc3b_mem_req mem_req,
   input  lc3b_types::lc3b_mem_rsp mem_rsp
);

   lc3b_types::lc3b_control_word ctrl;
   lc3b_types::lc3b_word         ir;
   lc3b_types::lc3b_aluop        aluop;
   lc3b_types::lc3b_word         alu_a;
   lc3b_types::lc3b_word         alu_b;
   lc3b_types::lc3b_word         alu_result;
   lc3b_types::lc3b_word         reg_wdata;
   lc3b_types::lc3b_word         rdata_a;
   lc3b_types::lc3b_word         rdata_b;
   logic [2:0]                   src_a;
   logic [2:0]                   src_b;
   logic [2:0]                   dest;
   logic                         reg_we;
   logic                         load_ir;
   logic                         load_mar;
   logic                         load_mdr;
   logic                         load_pc;
   logic                         load_regfile;
   logic                         load_cc;
   logic                         mem_start;
   logic                         mem_done;
   logic                         branch_taken;

   lc3b_control control (
      .clk          (clk),
      .reset        (reset),
      .ir           (ir),
      .mem_done     (mem_done),
      .branch_taken (branch_taken),
      .ctrl         (ctrl),
      .load_ir      (load_ir),
      .load_mar     (load_mar),
      .load_mdr     (load_mdr),
      .load_pc      (load_pc),
      .load_regfile (load_regfile),
      .load_cc      (load_cc),
      .mem_start    (mem_start)
   );

   lc3b_datapath #(
      .reset_pc (reset_pc)
   ) datapath (
      .clk          (clk),
      .reset        (reset),
      .ctrl         (ctrl),
      .load_ir      (load_ir),
      .load_mar     (load_mar),
      .load_mdr     (load_mdr),
      .load_pc      (load_pc),
      .load_regfile (load_regfile),
      .load_cc      (load_cc),
      .mem_start    (mem_start),
      .mem_done     (mem_done),
      .ir           (ir),
      .branch_taken (branch_taken),
      .aluop        (aluop),
      .alu_a        (alu_a),
      .alu_b        (alu_b),
      .alu_result   (alu_result),
      .src_a        (src_a),
      .src_b        (src_b),
      .dest         (dest),
      .reg_we       (reg_we),
      .reg_wdata    (reg_wdata),
      .rdata_a      (rdata_a),
      .rdata_b      (rdata_b),
      .mem_req      (mem_req),
      .mem_rsp      (mem_rsp)
   );

   lc3b_regfile regfile (
      .clk     (clk),
      .reset   (reset),
      .we      (reg_we),
      .src_a   (src_a),
      .src_b   (src_b),
      .dest    (dest),
      .wdata   (reg_wdata),
      .rdata_a (rdata_a),
      .rdata_b (rdata_b)
   );

   lc3b_alu alu (
      .aluop  (aluop),
      .a      (alu_a),
      .b      (alu_b),
      .result (alu_result)
   );

endmodule : lc3b_core

// ==== source/lc3b_datapath.sv ====
`timescale 1ns/1ps

module lc3b_datapath #(
   parameter lc3b_types::lc3b_word reset_pc = 16'h0000
) (
   input  logic                         clk,
   input  logic                         reset,
   input  lc3b_types::lc3b_control_word ctrl,
   input  logic                         load_ir,
   input  logic                         load_mar,
   input  logic                         load_mdr,
   input  logic                         load_pc,
   input  logic                         load_regfile,
   input  logic                         load_cc,
   input  logic                         mem_start,
   output logic                         mem_done,
   output lc3b_types::lc3b_word         ir,
   output logic                         branch_taken,
   output lc3b_types::lc3b_aluop        aluop,
   output lc3b_types::lc3b_word         alu_a,
   output lc3b_types::lc3b_word         alu_b,
   input  lc3b_types::lc3b_word         alu_result,
   output logic [2:0]                   src_a,
   output logic [2:0]                   src_b,
   output logic [2:0]                   dest,
   output logic                         reg_we,
   output lc3b_types::lc3b_word         reg_wdata,
   input  lc3b_types::lc3b_word         rdata_a,
   input  lc3b_types::lc3b_word         rdata_b,
   output lc3b_types::lc3b_mem_req      mem_req,
   input  lc3b_types::lc3b_mem_rsp      mem_rsp
);

   lc3b_types::lc3b_word pc;
   lc3b_types::lc3b_word mar;
   lc3b_types::lc3b_word mdr;
   logic [2:0]           cc; // n z p
   logic                 req_q;
   logic                 start_pend;
   lc3b_types::lc3b_word offset6;
   lc3b_types::lc3b_word pc_offset;
   lc3b_types::lc3b_word br_add;
   lc3b_types::lc3b_word pc_next;
   lc3b_types::lc3b_word mdr_next;
   lc3b_types::lc3b_word load_data;

   assign src_a = ir[8:6]; // sr1 or base
   assign src_b = ctrl.storemux_sel ? ir[11:9] : ir[2:0];
   assign dest = ctrl.destmux_sel ? 3'd7 : ir[11:9];
   assign aluop = ctrl.aluop;
   assign alu_a = rdata_a;

   // byte accesses use the offset unscaled
   assign offset6 = ctrl.wordinmux_sel ? {{10{ir[5]}}, ir[5:0]} : {{9{ir[5]}}, ir[5:0], 1'b0};

   always_comb begin
      case (ctrl.alumux_sel)
         2'b00:   alu_b = rdata_b;
         2'b01:   alu_b = offset6;
         2'b10:   alu_b = {{11{ir[4]}}, ir[4:0]}; // imm5
         default: alu_b = {12'h000, ir[3:0]};     // shift amount
      endcase
   end

   assign pc_offset = ctrl.offsetmux_sel ? {{4{ir[10]}}, ir[10:0], 1'b0}
                                         : {{6{ir[8]}}, ir[8:0], 1'b0};
   assign br_add = pc + pc_offset;
   assign branch_taken = |(ir[11:9] & cc);

   always_comb begin
      case (ctrl.pcmux_sel)
         2'b01:   pc_next = br_add;
         2'b10:   pc_next = alu_result;
         default: pc_next = pc + 16'd2;
      endcase
   end

   assign load_data = ctrl.wordinmux_sel ? {8'h00, (mar[0] ? mdr[15:8] : mdr[7:0])} : mdr;

   always_comb begin
      case (ctrl.regfilemux_sel)
         2'b00:   reg_wdata = alu_result;
         2'b01:   reg_wdata = load_data;
         2'b10:   reg_wdata = pc; // already advanced past the call
         default: reg_wdata = br_add;
      endcase
   end

   assign reg_we = load_regfile;

   always_comb begin
      case (ctrl.mdrmux_sel)
         2'b01:   mdr_next = mem_rsp.rdata;
         2'b10:   mdr_next = {rdata_b[7:0], rdata_b[7:0]};
         default: mdr_next = rdata_b;
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         pc <= reset_pc;
         ir <= '0;
         cc <= 3'b010;
      end else begin
         if (load_pc)
            pc <= pc_next;
         if (load_ir)
            ir <= mem_rsp.rdata;
         if (load_cc)
            cc <= {reg_wdata[15], reg_wdata == 16'h0000,
                   !reg_wdata[15] && reg_wdata != 16'h0000};
      end
   end

   always_ff @(posedge clk) begin
      if (load_mar)
         mar <= (ctrl.mem_read || ctrl.mem_write) ? alu_result : pc; // pc during fetch
      if (load_mdr)
         mdr <= mdr_next;
   end

   // a new start waits until the last ack has fallen
   always_ff @(posedge clk) begin
      if (reset) begin
         req_q <= 1'b0;
         start_pend <= 1'b0;
      end else if (req_q) begin
         if (mem_rsp.ack)
            req_q <= 1'b0;
      end else if ((mem_start || start_pend) && !mem_rsp.ack) begin
         req_q <= 1'b1;
         start_pend <= 1'b0;
      end else if (mem_start) begin
         start_pend <= 1'b1;
      end
   end

   assign mem_done = req_q & mem_rsp.ack;

   always_comb begin
      mem_req.req = req_q;
      mem_req.we = req_q & ctrl.mem_write;
      mem_req.addr = mar;
      mem_req.wdata = mdr;
      mem_req.byte_en = 2'b11;
      if (ctrl.mem_write && ctrl.wordinmux_sel)
         mem_req.byte_en = mar[0] ? 2'b10 : 2'b01; // lane by address lsb
   end

endmodule : lc3b_datapath

// ==== source/lc3b_alu.sv ====
`timescale 1ns/1ps

module lc3b_alu (
   input  lc3b_types::lc3b_aluop aluop,
   input  lc3b_types::lc3b_word  a,
   input  lc3b_types::lc3b_word  b,
   output lc3b_types::lc3b_word  result
);

   logic [3:0] shamt;

   assign shamt = b[3:0];

   always_comb begin
      case (aluop)
         lc3b_types::alu_add:  result = a + b;
         lc3b_types::alu_and:  result = a & b;
         lc3b_types::alu_not:  result = ~a;
         lc3b_types::alu_sll:  result = a << shamt;
         lc3b_types::alu_srl:  result = a >> shamt;
         lc3b_types::alu_sra:  result = $signed(a) >>> shamt; // sign fill
         default:              result = a; // pass
      endcase
   end

endmodule : lc3b_alu

// ==== source/lc3b_regfile.sv ====
`timescale 1ns/1ps

module lc3b_regfile (
   input  logic                 clk,
   input  logic                 reset,
   input  logic                 we,
   input  logic [2:0]           src_a,
   input  logic [2:0]           src_b,
   input  logic [2:0]           dest,
   input  lc3b_types::lc3b_word wdata,
   output lc3b_types::lc3b_word rdata_a,
   output lc3b_types::lc3b_word rdata_b
);

   lc3b_types::lc3b_word regs [8];

   always_ff @(posedge clk) begin
      if (reset) begin
         for (int i = 0; i < 8; i++)
            regs[i] <= '0;
      end else if (we) begin
         regs[dest] <= wdata;
      end
   end

   // read ports see the old value during a write cycle
   assign rdata_a = regs[src_a];
   assign rdata_b = regs[src_b];

endmodule : lc3b_regfile

// ==== source/lc3b_control.sv ====
`timescale 1ns/1ps

module lc3b_control (
   input  logic                         clk,
   input  logic                         reset,
   input  lc3b_types::lc3b_word         ir,
   input  logic                         mem_done,
   input  logic                         branch_taken,
   output lc3b_types::lc3b_control_word ctrl,
   output logic                         load_ir,
   output logic                         load_mar,
   output logic                         load_mdr,
   output logic                         load_pc,
   output logic                         load_regfile,
   output logic                         load_cc,
   output logic                         mem_start
);

   lc3b_types::lc3b_state        state;
   lc3b_types::lc3b_state        state_next;
   lc3b_types::lc3b_control_word rom_word;
   lc3b_types::lc3b_opcode       opcode;
   logic                         mem_op;
   logic                         in_fetch;
   logic                         in_wb;

   assign opcode = lc3b_types::lc3b_opcode'(ir[15:12]);

   control_rom rom (
      .opcode     (opcode),
      .bits4_5_11 ({ir[11], ir[5], ir[4]}),
      .ctrl       (rom_word)
   );

   assign mem_op = rom_word.mem_read | rom_word.mem_write;
   assign in_fetch = (state == lc3b_types::s_fetch) || (state == lc3b_types::s_fetch_wait);
   assign in_wb = (state == lc3b_types::s_writeback);

   always_comb begin
      ctrl = rom_word;
      if (in_fetch)
         ctrl = '0; // ir still holds the previous instruction
   end

   always_comb begin
      state_next = state;
      case (state)
         lc3b_types::s_fetch:      state_next = lc3b_types::s_fetch_wait;
         lc3b_types::s_fetch_wait: if (mem_done) state_next = lc3b_types::s_decode;
         lc3b_types::s_decode:     state_next = lc3b_types::s_execute;
         lc3b_types::s_execute:
            state_next = mem_op ? lc3b_types::s_mem : lc3b_types::s_writeback;
         lc3b_types::s_mem:        state_next = lc3b_types::s_mem_wait;
         lc3b_types::s_mem_wait:   if (mem_done) state_next = lc3b_types::s_writeback;
         default:                  state_next = lc3b_types::s_fetch;
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset)
         state <= lc3b_types::s_fetch;
      else
         state <= state_next;
   end

   assign mem_start = (state == lc3b_types::s_fetch) || (state == lc3b_types::s_mem);
   assign load_ir = (state == lc3b_types::s_fetch_wait) && mem_done;
   assign load_mar = (state == lc3b_types::s_fetch) ||
                     ((state == lc3b_types::s_execute) && mem_op);
   assign load_mdr = ((state == lc3b_types::s_execute) && rom_word.mem_write) ||
                     ((state == lc3b_types::s_mem_wait) && mem_done && rom_word.mem_read);

   // architectural state only changes once the instruction completes
   assign load_regfile = in_wb && rom_word.load_regfile;
   assign load_cc = in_wb && rom_word.load_cc;
   assign load_pc = (state == lc3b_types::s_fetch) ||
                    (in_wb && (rom_word.load_pc ||
                               (rom_word.opcode == lc3b_types::op_br && branch_taken)));

endmodule : lc3b_control

// ==== source/control_rom.sv ====
`timescale 1ns/1ps

module control_rom (
   input  lc3b_types::lc3b_opcode       opcode,
   input  logic [2:0]                   bits4_5_11,
   output lc3b_types::lc3b_control_word ctrl
);

   always_comb begin
      ctrl.opcode = opcode;
      ctrl.aluop = lc3b_types::alu_add;
      ctrl.load_cc = 1'b0;
      ctrl.load_regfile = 1'b0;
      ctrl.load_pc = 1'b0;
      ctrl.mem_read = 1'b0;
      ctrl.mem_write = 1'b0;
      ctrl.alumux_sel = 2'b00;
      ctrl.pcmux_sel = 2'b00;
      ctrl.offsetmux_sel = 1'b0;
      ctrl.storemux_sel = 1'b0;
      ctrl.destmux_sel = 1'b0;
      ctrl.regfilemux_sel = 2'b00;
      ctrl.mdrmux_sel = 2'b00;
      ctrl.wordinmux_sel = 1'b0;

      case (opcode)
         lc3b_types::op_add: begin
            if (bits4_5_11[1])
               ctrl.alumux_sel = 2'b10; // imm5 form
            ctrl.aluop = lc3b_types::alu_add;
            ctrl.load_cc = 1'b1;
            ctrl.load_regfile = 1'b1;
         end

         lc3b_types::op_and: begin
            if (bits4_5_11[1])
               ctrl.alumux_sel = 2'b10; // imm5 form
            ctrl.aluop = lc3b_types::alu_and;
            ctrl.load_cc = 1'b1;
            ctrl.load_regfile = 1'b1;
         end

         lc3b_types::op_not: begin
            ctrl.aluop = lc3b_types::alu_not;
            ctrl.load_cc = 1'b1;
            ctrl.load_regfile = 1'b1;
         end

         lc3b_types::op_shf: begin
            if (!bits4_5_11[0])
               ctrl.aluop = lc3b_types::alu_sll; // d clear
            else if (!bits4_5_11[1])
               ctrl.aluop = lc3b_types::alu_srl; // a clear
            else
               ctrl.aluop = lc3b_types::alu_sra;
            ctrl.alumux_sel = 2'b11; // imm4 amount
            ctrl.load_cc = 1'b1;
            ctrl.load_regfile = 1'b1;
         end

         lc3b_types::op_lea: begin
            ctrl.regfilemux_sel = 2'b11; // pc relative address
            ctrl.load_cc = 1'b1;
            ctrl.load_regfile = 1'b1;
         end

         lc3b_types::op_ldr: begin
            ctrl.aluop = lc3b_types::alu_add;
            ctrl.alumux_sel = 2'b01;
            ctrl.mem_read = 1'b1;
            ctrl.mdrmux_sel = 2'b01; // capture read data
            ctrl.regfilemux_sel = 2'b01;
            ctrl.load_cc = 1'b1;
            ctrl.load_regfile = 1'b1;
         end

         lc3b_types::op_ldb: begin
            ctrl.aluop = lc3b_types::alu_add;
            ctrl.alumux_sel = 2'b01;
            ctrl.mem_read = 1'b1;
            ctrl.mdrmux_sel = 2'b01;
            ctrl.regfilemux_sel = 2'b01;
            ctrl.wordinmux_sel = 1'b1; // zero extended byte
            ctrl.load_cc = 1'b1;
            ctrl.load_regfile = 1'b1;
         end

         lc3b_types::op_str: begin
            ctrl.aluop = lc3b_types::alu_add;
            ctrl.alumux_sel = 2'b01;
            ctrl.mem_write = 1'b1;
            ctrl.storemux_sel = 1'b1; // source is ir[11:9]
            ctrl.mdrmux_sel = 2'b00;
         end

         lc3b_types::op_stb: begin
            ctrl.aluop = lc3b_types::alu_add;
            ctrl.alumux_sel = 2'b01;
            ctrl.mem_write = 1'b1;
            ctrl.storemux_sel = 1'b1;
            ctrl.mdrmux_sel = 2'b10; // low byte in both lanes
            ctrl.wordinmux_sel = 1'b1;
         end

         lc3b_types::op_br: begin
            ctrl.pcmux_sel = 2'b01; // taken decision made in writeback
         end

         lc3b_types::op_jmp: begin // ret is jmp r7
            ctrl.aluop = lc3b_types::alu_pass;
            ctrl.pcmux_sel = 2'b10;
            ctrl.load_pc = 1'b1;
         end

         lc3b_types::op_jsr: begin
            ctrl.regfilemux_sel = 2'b10; // return pc into r7
            ctrl.destmux_sel = 1'b1;
            ctrl.load_regfile = 1'b1;
            ctrl.load_pc = 1'b1;
            if (bits4_5_11[2]) begin
               ctrl.offsetmux_sel = 1'b1; // offset11
               ctrl.pcmux_sel = 2'b01;
            end else begin
               ctrl.aluop = lc3b_types::alu_pass; // jsrr base
               ctrl.pcmux_sel = 2'b10;
            end
         end

         default: begin
            ctrl = '0;
         end
      endcase
   end

endmodule : control_rom

// ==== source/lc3b_types.sv ====
package lc3b_types;

typedef logic [15:0] lc3b_word;

// LC-3b opcode field in ir[15:12]
typedef enum logic [3:0] {
   op_br  = 4'b0000,
   op_add = 4'b0001,
   op_ldb = 4'b0010,
   op_stb = 4'b0011,
   op_jsr = 4'b0100,
   op_and = 4'b0101,
   op_ldr = 4'b0110,
   op_str = 4'b0111,
   op_not = 4'b1001,
   op_jmp = 4'b1100,
   op_shf = 4'b1101,
   op_lea = 4'b1110
} lc3b_opcode;

typedef enum logic [2:0] {
   alu_add,
   alu_and,
   alu_not,
   alu_pass,
   alu_sll,
   alu_srl,
   alu_sra
} lc3b_aluop;

typedef struct packed {
   lc3b_opcode opcode;
   lc3b_aluop  aluop;
   logic       load_cc;
   logic       load_regfile;
   logic       load_pc;
   logic       mem_read;
   logic       mem_write;
   logic [1:0] alumux_sel;     // sr2, offset6, imm5, imm4
   logic [1:0] pcmux_sel;      // pc+2, br_add, alu
   logic       offsetmux_sel;  // offset9 or offset11
   logic       storemux_sel;   // sr2 field or sr field
   logic       destmux_sel;    // dr or r7
   logic [1:0] regfilemux_sel; // alu, load data, pc, br_add
   logic [1:0] mdrmux_sel;     // sr word, mem data, sr byte twice
   logic       wordinmux_sel;  // byte access
} lc3b_control_word;

typedef enum logic [2:0] {
   s_fetch,
   s_fetch_wait,
   s_decode,
   s_execute,
   s_mem,
   s_mem_wait,
   s_writeback
} lc3b_state;

typedef struct packed {
   logic       req;
   logic       we;
   lc3b_word   addr;
   lc3b_word   wdata;
   logic [1:0] byte_en;
} lc3b_mem_req;

typedef struct packed {
   logic     ack;
   lc3b_word rdata;
} lc3b_mem_rsp;

endpackage : lc3b_types
